//--- filelist.f
+incdir+hw
hw/chromaDctPkg.sv
hw/dctCoefTable.sv
hw/dctRowPass.sv
hw/dctColumnPass.sv
hw/dctCoefSerializer.sv
hw/chromaDct2d.sv
testbench/chromaDct2d_props.sv
testbench/chromaDct2dTb.sv

//--- Bender.yml
package:
  name: chroma_dct

sources:
  - include_dirs:
      - hw
    files:
      - hw/chromaDctPkg.sv
      - hw/dctCoefTable.sv
      - hw/dctRowPass.sv
      - hw/dctColumnPass.sv
      - hw/dctCoefSerializer.sv
      - hw/chromaDct2d.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/chromaDct2d_props.sv
      - testbench/chromaDct2dTb.sv

//--- testbench/chromaDct2dTb.sv
// Sends whole 64-pixel blocks only and checks every coefficient against an integer model
`timescale 1ns/1ps
`include "chromaDct_cfg.svh"

module chromaDct2dTb;
	import chromaDctPkg::*;

	localparam time ClkPeriod = 100ns;
	localparam time DriveDelay = 10ns;
	localparam int NumEntries = 10;
	localparam int DrainTimeout = 400;
	localparam int LatencyCycles = 3;
	localparam real Pi = 3.14159265358979;

	typedef enum int {PatFlat, PatRamp, PatChecker, PatRandom} patternKind_t;

	// For random rows a parameter of 1 resends the previous random block
	typedef struct packed {
		patternKind_t kind;
		int param;
		logic gap;
	} stimEntry_t;

	logic clk;
	logic rst;
	logic pixelValid;
	pixel_t pixel;
	logic coefValid;
	dctCoef_t coef;

	stimEntry_t stimTable [NumEntries];
	int basis [8][8];
	int pixels [64];
	int lastRandom [64];
	dctCoef_t expectQueue [$];
	int acceptQueue [$];
	int cycleCount;
	int unsigned seed;
	int waited;
	dctCoef_t expectedCoef;
	int firstAccept;

	chromaDct2d dut_i (
		.clk(clk),
		.rst(rst),
		.pixelValid(pixelValid),
		.pixel(pixel),
		.coefValid(coefValid),
		.coef(coef)
	);

	initial begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
	end

	task automatic failRun(input string line);
		$display("%s", line);
		$display("SIMULATION FAILED");
		$fatal(1, "Stopping at the first failure");
	endtask

	task automatic checkCoef(input dctCoef_t actual, input dctCoef_t expected);
		if (actual !== expected) begin
			failRun($sformatf(
				"CHECK FAILED at %0t: got index %0d value %0d, expected index %0d value %0d",
				$time, actual.index, actual.value, expected.index, expected.value));
		end
	endtask

	task automatic checkLatency(input int actual, input int expected);
		if (actual != expected) begin
			failRun($sformatf(
				"CHECK FAILED at %0t: first coefficient after %0d edges, expected %0d",
				$time, actual, expected));
		end
	endtask

	// T[k][n] = round(2^14 * c_k * cos((2n+1)k*pi/16))
	function automatic int basisEntry(input int k, input int n);
		real scale;
		real value;
		scale = (k == 0) ? 1.0 / $sqrt(8.0) : 0.5;
		value = 16384.0 * scale * $cos((2 * n + 1) * k * Pi / 16.0);
		if (value >= 0.0)
			return $rtoi(value + 0.5);
		else
			return -$rtoi(0.5 - value);
	endfunction

	// Half up at bit 13, then keep 11 bits as a signed value
	function automatic int roundToOut(input longint sum);
		longint shifted;
		shifted = (sum + 64'sd8192) >>> 14;
		shifted = shifted & 64'sd2047;
		if (shifted >= 1024)
			shifted = shifted - 2048;
		return int'(shifted);
	endfunction

	task automatic buildBlock(input stimEntry_t entry);
		for (int i = 0; i < 64; i++) begin
			case (entry.kind)
				PatFlat: pixels[i] = entry.param;
				PatRamp: pixels[i] = (entry.param * i) % 256;
				PatChecker: pixels[i] = ((i / 8 + i % 8) % 2 == 1) ? entry.param : 255 - entry.param;
				default: begin
					if (entry.param == 0)
						lastRandom[i] = $urandom_range(255, 0);
					pixels[i] = lastRandom[i];
				end
			endcase
		end
	endtask

	// Row pass then column pass, queued in index order 8k+j
	task automatic predictBlock();
		longint sum;
		int rowOut [8][8];
		dctCoef_t expected;
		for (int r = 0; r < 8; r++) begin
			for (int k = 0; k < 8; k++) begin
				sum = 0;
				for (int c = 0; c < 8; c++)
					sum += longint'(basis[k][c]) * pixels[8 * r + c];
				if (k == 0)
					sum -= `DCT_DC_OFFSET;
				rowOut[k][r] = roundToOut(sum);
			end
		end
		for (int k = 0; k < 8; k++) begin
			for (int j = 0; j < 8; j++) begin
				sum = 0;
				for (int r = 0; r < 8; r++)
					sum += longint'(rowOut[k][r]) * basis[j][r];
				expected.index = coefIndex_t'(8 * k + j);
				expected.value = outValue_t'(roundToOut(sum));
				expectQueue.push_back(expected);
			end
		end
	endtask

	task automatic sendBlock(input stimEntry_t entry);
		int idle;
		for (int i = 0; i < 64; i++) begin
			pixelValid = 1'b1;
			pixel = pixel_t'(pixels[i]);
			@(posedge clk);
			#DriveDelay;
			// The edge that took the last pixel is the latency reference
			if (i == 63)
				acceptQueue.push_back(cycleCount);
			if (entry.gap && i != 63) begin
				idle = $urandom_range(3, 1);
				pixelValid = 1'b0;
				pixel = '0;
				repeat (idle) begin
					@(posedge clk);
					#DriveDelay;
				end
			end
		end
		pixelValid = 1'b0;
	endtask

	always @(negedge clk) begin
		if (!rst && coefValid === 1'b1) begin
			if (expectQueue.size() == 0)
				failRun("The DUT offered a coefficient when none was expected");
			expectedCoef = expectQueue.pop_front();
			checkCoef(coef, expectedCoef);
			if (coef.index == 0) begin
				if (acceptQueue.size() == 0)
					failRun("A block started before its last pixel was sent");
				firstAccept = acceptQueue.pop_front();
				checkLatency(cycleCount - firstAccept, LatencyCycles);
			end
		end
	end

	initial begin
		seed = 32'hb4ef;
		void'($urandom(seed));
		rst = 1'b1;
		pixelValid = 1'b0;
		pixel = '0;
		cycleCount = 0;
		for (int k = 0; k < 8; k++)
			for (int n = 0; n < 8; n++)
				basis[k][n] = basisEntry(k, n);

		// Rows 0 to 5 run back to back, the gap rows repeat earlier blocks
		stimTable[0] = '{PatFlat, 128, 1'b0};
		stimTable[1] = '{PatFlat, 0, 1'b0};
		stimTable[2] = '{PatFlat, 255, 1'b0};
		stimTable[3] = '{PatRamp, 3, 1'b0};
		stimTable[4] = '{PatChecker, 200, 1'b0};
		stimTable[5] = '{PatRandom, 0, 1'b0};
		stimTable[6] = '{PatRamp, 3, 1'b1};
		stimTable[7] = '{PatChecker, 200, 1'b1};
		stimTable[8] = '{PatRandom, 1, 1'b1};
		stimTable[9] = '{PatRandom, 0, 1'b0};

		repeat (3) @(posedge clk);
		#DriveDelay;
		rst = 1'b0;

		for (int e = 0; e < NumEntries; e++) begin
			buildBlock(stimTable[e]);
			predictBlock();
			sendBlock(stimTable[e]);
		end

		waited = 0;
		while ((expectQueue.size() != 0 || coefValid !== 1'b0) && waited < DrainTimeout) begin
			@(posedge clk);
			#DriveDelay;
			waited++;
		end
		if (expectQueue.size() != 0 || coefValid !== 1'b0) begin
			failRun("Timed out waiting for the last coefficients to leave the DUT");
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

//--- testbench/chromaDct2d_props.sv
// Watches the output stream only and relies on blocks arriving at least 64 cycles apart
`timescale 1ns/1ps
`include "chromaDct_cfg.svh"

module chromaDct2dProps (
	input logic clk,
	input logic rst,
	input logic coefValid,
	input chromaDctPkg::dctCoef_t coef
);
	import chromaDctPkg::*;

	localparam coefIndex_t LastIndex = coefIndex_t'(`DCT_N * `DCT_N - 1);

	// Covers every reset cycle and the first cycle after it
	quietInReset: assert property (@(posedge clk) rst |=> !coefValid)
		else $error("coefValid was high during reset or on the cycle after it");

	// A run that starts at index 0 reaches the last index 63 cycles later
	fullRun: assert property (@(posedge clk) disable iff (rst)
		(coefValid && coef.index == '0) |-> ##63 (coefValid && coef.index == LastIndex))
		else $error("A coefficient run did not last 64 cycles");

	// After the last index the stream stops or a new block starts at zero
	runEnd: assert property (@(posedge clk) disable iff (rst)
		(coefValid && coef.index == LastIndex) |=> (!coefValid || coef.index == '0))
		else $error("coefValid continued past index 63 without a new block");

	indexStep: assert property (@(posedge clk) disable iff (rst)
		(coefValid && coef.index != LastIndex) |=>
			(coefValid && coef.index == coefIndex_t'($past(coef.index) + 1'b1)))
		else $error("The coefficient index did not step by one");

endmodule

bind chromaDct2d chromaDct2dProps props_i (
	.clk(clk),
	.rst(rst),
	.coefValid(coefValid),
	.coef(coef)
);

//--- hw/chromaDct2d.sv
// Pixels must come in whole 64-pixel blocks and every coefficient must be taken when offered
`timescale 1ns/1ps
`include "chromaDct_cfg.svh"

module chromaDct2d (
	input logic clk,
	input logic rst,
	input logic pixelValid,
	input chromaDctPkg::pixel_t pixel,
	output logic coefValid,
	output chromaDctPkg::dctCoef_t coef
);
	import chromaDctPkg::*;

	logic rowValid;
	rowResult_t rowResult;
	logic blockValid;
	dctBlock_t block;

	// One-dimensional transform of each image row
	dctRowPass rowPass_i (
		.clk(clk),
		.rst(rst),
		.pixelValid(pixelValid),
		.pixel(pixel),
		.rowValid(rowValid),
		.rowResult(rowResult)
	);

	// Transposed coefficients over the eight row results
	dctColumnPass columnPass_i (
		.clk(clk),
		.rst(rst),
		.rowValid(rowValid),
		.rowResult(rowResult),
		.blockValid(blockValid),
		.block(block)
	);

	dctCoefSerializer serializer_i (
		.clk(clk),
		.rst(rst),
		.blockValid(blockValid),
		.block(block),
		.coefValid(coefValid),
		.coef(coef)
	);

endmodule

//--- hw/dctCoefSerializer.sv
// Assumes blocks arrive at least 64 cycles apart since the output has no back-pressure
`timescale 1ns/1ps
`include "chromaDct_cfg.svh"

module dctCoefSerializer (
	input logic clk,
	input logic rst,
	input logic blockValid,
	input chromaDctPkg::dctBlock_t block,
	output logic coefValid,
	output chromaDctPkg::dctCoef_t coef
);
	import chromaDctPkg::*;

	localparam coefIndex_t LastIndex = coefIndex_t'(`DCT_N * `DCT_N - 1);

	dctBlock_t held;
	coefIndex_t index;

	always_ff @(posedge clk) begin
		if (rst) begin
			coefValid <= 1'b0;
			index <= '0;
		end else if (blockValid) begin
			// A new block wins even over the last coefficient of the previous one
			coefValid <= 1'b1;
			index <= '0;
		end else if (coefValid) begin
			index <= index + 1'b1;
			if (index == LastIndex) begin
				coefValid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (blockValid) begin
			held <= block;
		end
	end

	// Both the index and the held block are registers, so the output is glitch free
	assign coef.index = index;
	assign coef.value = held[index];

endmodule

//--- hw/dctColumnPass.sv
// Takes exactly eight row results per block and cannot resynchronise to a block boundary
`timescale 1ns/1ps
`include "chromaDct_cfg.svh"

module dctColumnPass (
	input logic clk,
	input logic rst,
	input logic rowValid,
	input chromaDctPkg::rowResult_t rowResult,
	output logic blockValid,
	output chromaDctPkg::dctBlock_t block
);
	import chromaDctPkg::*;

	localparam int Cells = `DCT_N * `DCT_N;

	logic [2:0] rowCount;
	coefVector_t colCoefs;
	acc_t product [Cells];
	accWord_u acc [Cells];
	accWord_u sumNext [Cells];

	// Column r of the basis matrix gives T[j][r] for every j
	dctCoefTable coefTable_i (
		.sampleIndex(rowCount),
		.coefs(colCoefs)
	);

	always_comb begin
		for (int k = 0; k < `DCT_N; k++) begin
			for (int j = 0; j < `DCT_N; j++) begin
				product[k*`DCT_N + j] = rowResult[k] * colCoefs[j];
			end
		end
		for (int i = 0; i < Cells; i++) begin
			// Row 0 loads, the remaining rows accumulate
			if (rowCount == 3'd0) begin
				sumNext[i].raw = product[i];
			end else begin
				sumNext[i].raw = acc[i].raw + product[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rowCount <= '0;
			blockValid <= 1'b0;
		end else begin
			blockValid <= rowValid && (rowCount == 3'd7);
			if (rowValid) begin
				rowCount <= rowCount + 3'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rowValid) begin
			for (int i = 0; i < Cells; i++) begin
				acc[i] <= sumNext[i];
			end
			// The eighth row is rounded straight from the adder outputs
			if (rowCount == 3'd7) begin
				for (int i = 0; i < Cells; i++) begin
					block[i] <= roundAcc(sumNext[i]);
				end
			end
		end
	end

endmodule

//--- hw/dctRowPass.sv
// Expects row-major pixels with no framing, so the first pixel after reset starts row 0
`timescale 1ns/1ps
`include "chromaDct_cfg.svh"

module dctRowPass (
	input logic clk,
	input logic rst,
	input logic pixelValid,
	input chromaDctPkg::pixel_t pixel,
	output logic rowValid,
	output chromaDctPkg::rowResult_t rowResult
);
	import chromaDctPkg::*;

	logic [2:0] column;
	logic rowDone;
	coefVector_t rowCoefs;
	logic signed [`DCT_PIX_W:0] pixSigned;
	acc_t product [`DCT_N];
	accWord_u acc [`DCT_N];
	accWord_u sumNext [`DCT_N];
	accWord_u finalSum [`DCT_N];

	dctCoefTable coefTable_i (
		.sampleIndex(column),
		.coefs(rowCoefs)
	);

	// Zero extension keeps the pixel positive in the signed multiply
	assign pixSigned = {1'b0, pixel};

	always_comb begin
		for (int k = 0; k < `DCT_N; k++) begin
			product[k] = pixSigned * rowCoefs[k];
			// Column 0 starts a new row, so the old sum is dropped
			sumNext[k].raw = (column == 3'd0) ? product[k] : acc[k].raw + product[k];
			finalSum[k].raw = sumNext[k].raw;
		end
		// Re-centres the pixels around zero for the DC term only
		finalSum[0].raw = sumNext[0].raw - acc_t'(`DCT_DC_OFFSET);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			column <= '0;
			rowDone <= 1'b0;
			rowValid <= 1'b0;
		end else begin
			// The row result is registered with the last pixel and announced one edge later
			rowDone <= pixelValid && (column == 3'd7);
			rowValid <= rowDone;
			if (pixelValid) begin
				column <= column + 3'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pixelValid) begin
			for (int k = 0; k < `DCT_N; k++) begin
				acc[k] <= sumNext[k];
			end
			// The last pixel's product is folded in straight from the adders
			if (column == 3'd7) begin
				for (int k = 0; k < `DCT_N; k++) begin
					rowResult[k] <= roundAcc(finalSum[k]);
				end
			end
		end
	end

endmodule

//--- hw/dctCoefTable.sv
// Purely combinational, returns column n of the 2^14 scaled 8x8 DCT basis matrix
`timescale 1ns/1ps
`include "chromaDct_cfg.svh"

module dctCoefTable (
	input logic [2:0] sampleIndex,
	output chromaDctPkg::coefVector_t coefs
);
	import chromaDctPkg::*;

	// T[freq][sample] from the angle (2n+1)k in units of pi/16
	function automatic coef_t basisValue(input logic [2:0] freq, input logic [2:0] sample);
		logic [4:0] phase;
		logic [4:0] folded;
		logic negate;
		coef_t magnitude;

		// One full turn is 32 units, so the cast wraps the angle
		phase = 5'((2 * sample + 1) * freq);
		folded = (phase > 5'd16) ? 5'(6'd32 - {1'b0, phase}) : phase;

		// Past a quarter turn the cosine is negative
		negate = folded > 5'd8;
		if (negate) begin
			folded = 5'(5'd16 - folded);
		end

		// Index 0 only occurs for DC, and cos(pi/4)/2 equals c0 as well
		case (folded)
			5'd0, 5'd4: magnitude = coef_t'(`DCT_C0);
			5'd1: magnitude = coef_t'(`DCT_C1);
			5'd2: magnitude = coef_t'(`DCT_C2);
			5'd3: magnitude = coef_t'(`DCT_C3);
			5'd5: magnitude = coef_t'(`DCT_C5);
			5'd6: magnitude = coef_t'(`DCT_C6);
			5'd7: magnitude = coef_t'(`DCT_C7);
			default: magnitude = '0;
		endcase

		return negate ? -magnitude : magnitude;
	endfunction

	always_comb begin
		for (int k = 0; k < `DCT_N; k++) begin
			coefs[k] = basisValue(3'(k), sampleIndex);
		end
	end

endmodule

//--- hw/chromaDctPkg.sv
// Types for the DCT datapath, where the accumulator field split assumes DCT_FRAC_W of 14
`include "chromaDct_cfg.svh"

package chromaDctPkg;

	typedef logic [`DCT_PIX_W-1:0] pixel_t;

	typedef logic signed [`DCT_COEF_W-1:0] coef_t;

	// Indexed by frequency
	typedef coef_t [`DCT_N-1:0] coefVector_t;

	typedef logic signed [`DCT_ACC_W-1:0] acc_t;

	typedef struct packed {
		logic [`DCT_ACC_W-`DCT_FRAC_W-1:0] intPart;
		logic roundBit;
		logic [`DCT_FRAC_W-2:0] fraction;
	} accFields_t;

	// One accumulator word, seen as a signed sum or split for rounding
	typedef union packed {
		acc_t raw;
		accFields_t fields;
	} accWord_u;

	typedef logic signed [`DCT_OUT_W-1:0] outValue_t;

	typedef outValue_t [`DCT_N-1:0] rowResult_t;

	// Element 8k+j holds frequency pair (k, j)
	typedef outValue_t [`DCT_N*`DCT_N-1:0] dctBlock_t;

	typedef logic [$clog2(`DCT_N*`DCT_N)-1:0] coefIndex_t;

	typedef struct packed {
		coefIndex_t index;
		outValue_t value;
	} dctCoef_t;

	// Round half up at the top fraction bit and keep the low output bits
	function automatic outValue_t roundAcc(input accWord_u word);
		return outValue_t'(word.fields.intPart + word.fields.roundBit);
	endfunction

endpackage

//--- hw/chromaDct_cfg.svh
// Sizes and constants assume unsigned 8-bit samples and basis coefficients scaled by 2^14
`ifndef CHROMA_DCT_CFG_SVH
`define CHROMA_DCT_CFG_SVH

// Block side and data widths
`define DCT_N 8
`define DCT_PIX_W 8
`define DCT_COEF_W 15
`define DCT_OUT_W 11

// Leaves two bits over the widest column pass sum
`define DCT_ACC_W 27

// The round bit is the top fraction bit
`define DCT_FRAC_W 14

// Basis magnitudes, round(2^14 * c_k * cos(m*pi/16))
`define DCT_C0 5793
`define DCT_C1 8035
`define DCT_C2 7568
`define DCT_C3 6811
`define DCT_C5 4551
`define DCT_C6 3135
`define DCT_C7 1598

// Eight pixels of 128 weighted by C0, removed from the DC sum instead of offsetting pixels
`define DCT_DC_OFFSET 5932032

`endif
